// ==== source/mempool_pkg.sv ====
/*
 * Shared widths and types of the memory cluster.
 * The group count is fixed at four and the bank field at two bits,
 * so every group holds four word-interleaved banks.
 * Addresses are byte addresses. The two lowest bits select a byte
 * inside a word and are ignored by the banks.
 */
package mempool_pkg;

  localparam int unsigned NumGroups     = 4;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned BeWidth       = DataWidth / 8;
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned GroupIdxWidth = 2;
  localparam int unsigned ByteOffWidth  = 2;
  localparam int unsigned BankIdxWidth  = 2;

  localparam int unsigned NumBanksPerGroup = 2 ** BankIdxWidth;
  // Everything above the group field
  localparam int unsigned RowWidth =
      AddrWidth - ByteOffWidth - BankIdxWidth - GroupIdxWidth;

  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [BeWidth-1:0]       strb_t;
  typedef logic [GroupIdxWidth-1:0] group_id_t;
  typedef logic [BankIdxWidth-1:0]  bank_id_t;
  typedef logic [RowWidth-1:0]      row_t;

  // Word interleaving across banks first, then across groups
  typedef struct packed {
    row_t                    row;
    group_id_t               group;
    bank_id_t                bank;
    logic [ByteOffWidth-1:0] byte_off;
  } tcdm_addr_fields_t;

  // Same address word, seen flat or split into its fields
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    tcdm_addr_fields_t    fields;
  } tcdm_addr_u;

  typedef struct packed {
    tcdm_addr_u addr;
    logic       wen;
    strb_t      be;
    data_t      wdata;
  } tcdm_req_t;

  // Writes return the merged word as well
  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

endpackage : mempool_pkg

// ==== source/tcdm_if.sv ====
/*
 * One request/response channel between the distributor, a group and
 * the collector. Both halves use valid/ready. Valid never waits for
 * ready and holds its payload until the transfer.
 * The distributor drives only the request half of the master side,
 * the collector only the response half.
 */
interface tcdm_if;
  import mempool_pkg::*;

  tcdm_req_t  req;
  logic       req_valid;
  logic       req_ready;
  tcdm_resp_t resp;
  logic       resp_valid;
  logic       resp_ready;

  modport master (
    output req,
    output req_valid,
    input  req_ready,
    input  resp,
    input  resp_valid,
    output resp_ready
  );

  modport slave (
    input  req,
    input  req_valid,
    output req_ready,
    output resp,
    output resp_valid,
    input  resp_ready
  );

endinterface : tcdm_if

// ==== source/tcdm_dispatch.sv ====
/*
 * Request distributor. Routes each request to the group named in its
 * address and logs the group id in the collector's order queue.
 * Purely combinational apart from one flop that keeps ready low
 * until the first clock edge after reset.
 * Ready is withheld while the order queue is full.
 */
module tcdm_dispatch (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Upstream request
  input  mempool_pkg::tcdm_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  // Request half of each group channel
  tcdm_if.master                 grp [mempool_pkg::NumGroups-1:0],
  // Order queue
  output logic                   order_push_o,
  output mempool_pkg::group_id_t order_gid_o,
  input  logic                   order_full_i
);
  import mempool_pkg::*;

  logic                 ready_en_q;
  group_id_t            sel_gid;
  logic [NumGroups-1:0] grp_ready;
  logic                 issue_ok;
  logic                 accept;

  // Held low through reset, released on the first edge after it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
    end
  end

  assign sel_gid = req_i.addr.fields.group;

  // Order full only rises on a push, so gated valid stays stable
  assign issue_ok = ready_en_q & ~order_full_i;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_route
    assign grp[g].req       = req_i;
    assign grp[g].req_valid = req_valid_i & issue_ok & (sel_gid == group_id_t'(g));
    assign grp_ready[g]     = grp[g].req_ready;
  end : gen_route

  assign req_ready_o = issue_ok & grp_ready[sel_gid];
  assign accept      = req_valid_i & req_ready_o;

  // One push per accepted request, same cycle as the group transfer
  assign order_push_o = accept;
  assign order_gid_o  = sel_gid;

endmodule : tcdm_dispatch

// ==== source/mempool_group.sv ====
/*
 * One memory group of four word-interleaved banks with byte enables.
 * A request is taken in one cycle and its response is presented from
 * a register in the next. Reads return the stored word, writes the
 * word as it stands after the byte merge.
 * BankDepth must be a power of two. Row bits above it are ignored,
 * so addresses alias modulo the group size.
 */
module mempool_group #(
  parameter int unsigned BankDepth = 64
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  tcdm_if.slave  tcdm
);
  import mempool_pkg::*;

  localparam int unsigned RowIdxWidth = (BankDepth > 1) ? $clog2(BankDepth) : 1;

  logic [RowIdxWidth-1:0]              row_idx;
  bank_id_t                            bank_idx;
  data_t [NumBanksPerGroup-1:0]        bank_rdata;
  data_t                               old_word;
  data_t                               new_word;
  data_t                               resp_word;
  logic                                req_fire;
  logic                                resp_valid_q;
  tcdm_resp_t                          resp_q;

  assign bank_idx = tcdm.req.addr.fields.bank;
  assign row_idx  = tcdm.req.addr.fields.row[RowIdxWidth-1:0];

  // Free when empty or when the held response leaves this cycle
  assign tcdm.req_ready = ~resp_valid_q | tcdm.resp_ready;
  assign req_fire       = tcdm.req_valid & tcdm.req_ready;

  for (genvar b = 0; b < NumBanksPerGroup; b++) begin : gen_banks
    data_t mem_q [BankDepth];

    assign bank_rdata[b] = mem_q[row_idx];

    always_ff @(posedge clk_i) begin
      if (req_fire && tcdm.req.wen && (bank_idx == bank_id_t'(b))) begin
        mem_q[row_idx] <= new_word;
      end
    end
  end : gen_banks

  // Byte merge of the write data into the addressed word
  always_comb begin
    old_word = bank_rdata[bank_idx];
    new_word = old_word;
    for (int unsigned i = 0; i < BeWidth; i++) begin
      if (tcdm.req.be[i]) begin
        new_word[8*i +: 8] = tcdm.req.wdata[8*i +: 8];
      end
    end
  end

  assign resp_word = tcdm.req.wen ? new_word : old_word;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (tcdm.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.rdata <= resp_word;
    end
  end

  assign tcdm.resp       = resp_q;
  assign tcdm.resp_valid = resp_valid_q;

endmodule : mempool_group

// ==== source/response_merge.sv ====
/*
 * Response collector. A FIFO of group ids keeps the issue order, and
 * only the group at its head may hand over a response. That response
 * is passed out combinationally.
 * Up to OrderDepth requests can be outstanding. The queue reports full
 * at that level and the distributor then stops accepting.
 */
module response_merge #(
  parameter int unsigned OrderDepth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Response half of each group channel
  tcdm_if.master                  grp [mempool_pkg::NumGroups-1:0],
  // Order queue
  input  logic                    order_push_i,
  input  mempool_pkg::group_id_t  order_gid_i,
  output logic                    order_full_o,
  // Downstream response
  output mempool_pkg::tcdm_resp_t resp_o,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i
);
  import mempool_pkg::*;

  localparam int unsigned PtrWidth = (OrderDepth > 1) ? $clog2(OrderDepth) : 1;
  localparam int unsigned CntWidth = $clog2(OrderDepth + 1);

  group_id_t                     gid_q [OrderDepth];
  logic [PtrWidth-1:0]           wr_ptr_q;
  logic [PtrWidth-1:0]           rd_ptr_q;
  logic [CntWidth-1:0]           count_q;
  logic                          empty;
  group_id_t                     head_gid;
  logic                          pop;
  logic [NumGroups-1:0]          grp_valid;
  tcdm_resp_t [NumGroups-1:0]    grp_resp;

  // Wraps for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] ptr_next(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(OrderDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty        = (count_q == '0);
  assign order_full_o = (count_q == CntWidth'(OrderDepth));
  assign head_gid     = gid_q[rd_ptr_q];

  for (genvar g = 0; g < NumGroups; g++) begin : gen_collect
    assign grp_valid[g]      = grp[g].resp_valid;
    assign grp_resp[g]       = grp[g].resp;
    // Other groups hold their responses until they reach the head
    assign grp[g].resp_ready = resp_ready_i & ~empty & (head_gid == group_id_t'(g));
  end : gen_collect

  assign resp_valid_o = ~empty & grp_valid[head_gid];
  assign resp_o       = grp_resp[head_gid];
  assign pop          = resp_valid_o & resp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (order_push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (order_push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !order_push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (order_push_i) begin
      gid_q[wr_ptr_q] <= order_gid_i;
    end
  end

endmodule : response_merge

// ==== source/mempool.sv ====
/*
 * Cluster top level. One request port fans out over four memory groups
 * and one response port returns the results in request order.
 * With resp_ready_i high, a response follows its request by one cycle.
 * req_ready_o stays low until the first clock after reset.
 * BankDepth must be a power of two.
 */
module mempool #(
  parameter int unsigned BankDepth  = 64,
  parameter int unsigned OrderDepth = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Request port
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [mempool_pkg::AddrWidth-1:0]   req_addr_i,
  input  logic                                req_wen_i,
  input  logic [mempool_pkg::BeWidth-1:0]     req_be_i,
  input  logic [mempool_pkg::DataWidth-1:0]   req_wdata_i,
  // Response port
  output logic                                resp_valid_o,
  input  logic                                resp_ready_i,
  output logic [mempool_pkg::DataWidth-1:0]   resp_rdata_o
);
  import mempool_pkg::*;

  tcdm_req_t  req;
  tcdm_resp_t resp;
  logic       order_push;
  group_id_t  order_gid;
  logic       order_full;

  // Request half driven by the distributor, response half by the collector
  tcdm_if grp_bus [NumGroups-1:0] ();

  assign req.addr.flat = req_addr_i;
  assign req.wen       = req_wen_i;
  assign req.be        = req_be_i;
  assign req.wdata     = req_wdata_i;

  assign resp_rdata_o = resp.rdata;

  tcdm_dispatch i_dispatch (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_i        (req         ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .grp          (grp_bus     ),
    .order_push_o (order_push  ),
    .order_gid_o  (order_gid   ),
    .order_full_i (order_full  )
  );

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    mempool_group #(
      .BankDepth (BankDepth)
    ) i_group (
      .clk_i   (clk_i     ),
      .rst_n_i (rst_n_i   ),
      .tcdm    (grp_bus[g])
    );
  end : gen_groups

  response_merge #(
    .OrderDepth (OrderDepth)
  ) i_merge (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .grp          (grp_bus     ),
    .order_push_i (order_push  ),
    .order_gid_i  (order_gid   ),
    .order_full_o (order_full  ),
    .resp_o       (resp        ),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule : mempool

// ==== verification/mempool_checker.sv ====
/*
 * Handshake assertions on the top-level ports of the cluster.
 * Bound to every mempool instance. Tracks the number of outstanding
 * requests itself, so it needs no access to DUT internals.
 */
module mempool_checker (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        req_valid_i,
  input logic        req_ready_o,
  input logic [31:0] req_addr_i,
  input logic        req_wen_i,
  input logic [3:0]  req_be_i,
  input logic [31:0] req_wdata_i,
  input logic        resp_valid_o,
  input logic        resp_ready_i,
  input logic [31:0] resp_rdata_o
);

  int unsigned outstanding_q;
  // Number of failed assertions
  int unsigned fail_cnt = 0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + (req_valid_i && req_ready_o)
                       - (resp_valid_o && resp_ready_i);
    end
  end

  // Request payload held while stalled
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_addr_i) &&
    $stable(req_wen_i) && $stable(req_be_i) && $stable(req_wdata_i))
    else begin
      fail_cnt++;
      $error("request changed before it was accepted");
    end

  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o))
    else begin
      fail_cnt++;
      $error("response changed before it was taken");
    end

  resp_reset_a: assert property (@(posedge clk_i) !rst_n_i |-> !resp_valid_o)
    else begin
      fail_cnt++;
      $error("response valid during reset");
    end

  resp_owed_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o |-> outstanding_q != 0)
    else begin
      fail_cnt++;
      $error("response without an outstanding request");
    end

endmodule : mempool_checker

bind mempool mempool_checker i_checker (.*);

// ==== verification/tb_mempool.sv ====
/*
 * Testbench for the memory cluster. Uses 64 words spread over all
 * groups and banks, which are fully written first so that no read
 * returns an unwritten word. Expected words come from a model memory.
 */
module tb_mempool;

  localparam int unsigned NumInit   = 64;
  localparam int unsigned NumPairs  = 8;
  localparam int unsigned NumMerge  = 20;
  localparam int unsigned NumBurst  = 40;
  localparam int unsigned NumRandom = 60;
  localparam int unsigned NumReqs   = NumInit + 2 * NumPairs + 2 * NumMerge + NumBurst + NumRandom;
  localparam int unsigned CycleLimit = 10 * NumReqs + 100;
  localparam int unsigned OrderDepth = 4;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic [31:0] req_addr_i;
  logic        req_wen_i;
  logic [3:0]  req_be_i;
  logic [31:0] req_wdata_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic [31:0] resp_rdata_o;

  logic [31:0]  lfsr_state;
  logic [31:0]  ref_mem [64];
  logic [31:0]  exp_q [$];
  logic [1:0]   gid_q [$];
  int unsigned  acc_cycle_q [$];
  int unsigned  cycle_cnt;
  int unsigned  outstanding;
  int unsigned  mismatch_cnt;
  int unsigned  other_cnt;
  int unsigned  stall_cnt;
  logic         strict_latency;
  logic         random_ready;

  mempool #(
    .BankDepth  (64),
    .OrderDepth (OrderDepth)
  ) i_mempool (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_wen_i    (req_wen_i),
    .req_be_i     (req_be_i),
    .req_wdata_i  (req_wdata_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

  always #5 clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] random_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  // Word index bits from the low end: bank, group, row
  function automatic logic [31:0] word_addr(input logic [5:0] idx);
    return {24'b0, idx, 2'b00};
  endfunction

  // Applies one accepted request to the model, returns the response word
  function automatic logic [31:0] model_access(input logic [31:0] addr, input logic wen,
                                               input logic [3:0] be, input logic [31:0] wdata);
    logic [5:0]  idx;
    logic [31:0] word;
    idx  = addr[7:2];
    word = ref_mem[idx];
    if (wen) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          word[8*i +: 8] = wdata[8*i +: 8];
        end
      end
      ref_mem[idx] = word;
    end
    return word;
  endfunction

  // True while an outstanding request targets this group
  function automatic logic group_busy(input logic [1:0] gid);
    foreach (gid_q[i]) begin
      if (gid_q[i] == gid) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Drives one request from a falling edge until it is accepted
  task automatic issue(input logic [31:0] addr, input logic wen,
                       input logic [3:0] be, input logic [31:0] wdata);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_wen_i   = wen;
    req_be_i    = be;
    req_wdata_i = wdata;
    resp_ready_i = random_ready ? 1'(random_bits(1)) : 1'b1;
    forever begin
      @(posedge clk_i);
      if (req_ready_o) begin
        break;
      end
      @(negedge clk_i);
      resp_ready_i = random_ready ? 1'(random_bits(1)) : 1'b1;
    end
  endtask

  task automatic drain();
    @(negedge clk_i);
    req_valid_i  = 1'b0;
    resp_ready_i = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // Response compare, acceptance log, and port-level checks
  always @(posedge clk_i) begin
    int unsigned acc;
    logic [31:0] expected;
    logic [1:0]  tgt;
    logic        ready_exp;
    cycle_cnt <= cycle_cnt + 1;
    // Expected ready from queue level and target group state
    tgt       = req_addr_i[5:4];
    ready_exp = (outstanding < OrderDepth) &&
                (!group_busy(tgt) || (resp_ready_i && gid_q[0] == tgt));
    if (rst_n_i && req_valid_i && req_ready_o !== ready_exp) begin
      mismatch_cnt++;
      $display("MISMATCH at time %0t: req_ready_o %b, expected %b", $time, req_ready_o,
               ready_exp);
    end
    if (!rst_n_i && resp_valid_o) begin
      other_cnt++;
      $display("Response valid was high during reset at time %0t", $time);
    end
    if (rst_n_i && resp_valid_o && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("A response arrived with no request outstanding at time %0t", $time);
      end else begin
        expected = exp_q.pop_front();
        acc = acc_cycle_q.pop_front();
        void'(gid_q.pop_front());
        if (resp_rdata_o !== expected) begin
          mismatch_cnt++;
          $display("MISMATCH at time %0t: rdata %h, expected %h", $time, resp_rdata_o,
                   expected);
        end
        if (strict_latency && (cycle_cnt != acc + 1)) begin
          mismatch_cnt++;
          $display("MISMATCH at time %0t: response %0d cycles after acceptance, expected 1",
                   $time, cycle_cnt - acc);
        end
      end
    end
    if (rst_n_i && req_valid_i && !req_ready_o) begin
      stall_cnt++;
    end
    if (rst_n_i && req_valid_i && req_ready_o) begin
      exp_q.push_back(model_access(req_addr_i, req_wen_i, req_be_i, req_wdata_i));
      acc_cycle_q.push_back(cycle_cnt);
      gid_q.push_back(req_addr_i[5:4]);
    end
    outstanding <= outstanding + (rst_n_i && req_valid_i && req_ready_o)
                   - (rst_n_i && resp_valid_o && resp_ready_i);
    if (cycle_cnt > CycleLimit) begin
      $display("Timeout after %0d cycles, responses still missing", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [5:0] idx;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_addr_i     = '0;
    req_wen_i      = 1'b0;
    req_be_i       = '0;
    req_wdata_i    = '0;
    resp_ready_i   = 1'b1;
    lfsr_state     = 32'ha21d_4dbf;
    cycle_cnt      = 0;
    outstanding    = 0;
    mismatch_cnt   = 0;
    other_cnt      = 0;
    stall_cnt      = 0;
    strict_latency = 1'b0;
    random_ready   = 1'b0;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // Idle cycles, no response may show up
    repeat (3) @(negedge clk_i);

    // Full-word fill of every used word
    for (int i = 0; i < NumInit; i++) begin
      issue(word_addr(6'(i)), 1'b1, 4'hf, random_bits(32));
    end
    drain();

    // Write then read back
    for (int i = 0; i < NumPairs; i++) begin
      idx = 6'(random_bits(6));
      issue(word_addr(idx), 1'b1, 4'hf, random_bits(32));
      issue(word_addr(idx), 1'b0, 4'h0, random_bits(32));
    end
    drain();

    // Partial writes
    for (int i = 0; i < NumMerge; i++) begin
      idx = 6'(random_bits(6));
      issue(word_addr(idx), 1'b1, 4'(random_bits(4)), random_bits(32));
      issue(word_addr(idx), 1'b0, 4'h0, '0);
    end
    drain();

    // Back to back, one-cycle latency
    strict_latency = 1'b1;
    for (int i = 0; i < NumBurst; i++) begin
      issue(word_addr(6'(random_bits(6))), 1'(random_bits(1)), 4'(random_bits(4)),
            random_bits(32));
    end
    drain();
    strict_latency = 1'b0;

    // Random back-pressure
    random_ready = 1'b1;
    stall_cnt    = 0;
    for (int i = 0; i < NumRandom; i++) begin
      issue(word_addr(6'(random_bits(6))), 1'(random_bits(1)), 4'(random_bits(4)),
            random_bits(32));
    end
    random_ready = 1'b0;
    drain();
    if (stall_cnt == 0) begin
      other_cnt++;
      $display("Request ready never fell under back-pressure");
    end

    repeat (2) @(negedge clk_i);
    // Bound checker assertion failures
    other_cnt += i_mempool.i_checker.fail_cnt;
    $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_mempool

// ==== files.f ====
source/mempool_pkg.sv
source/tcdm_if.sv
source/tcdm_dispatch.sv
source/mempool_group.sv
source/response_merge.sv
source/mempool.sv
verification/mempool_checker.sv
verification/tb_mempool.sv

// ==== Bender.yml ====
package:
  name: mempool_cluster

sources:
  - files:
      - source/mempool_pkg.sv
      - source/tcdm_if.sv
      - source/tcdm_dispatch.sv
      - source/mempool_group.sv
      - source/response_merge.sv
      - source/mempool.sv
  - target: test
    files:
      - verification/mempool_checker.sv
      - verification/tb_mempool.sv
